// ==== design/daq_core_defines.svh ====
`ifndef DAQ_CORE_DEFINES_SVH
`define DAQ_CORE_DEFINES_SVH

// Local bus geometry
`define DAQ_ABUS_WIDTH 16
`define DAQ_DBUS_WIDTH 8

// System region, 256 bytes
`define DAQ_SYS_BASE 16'h0300
`define DAQ_SYS_SIZE 16'h0100

// GPIO region, up to the system window
`define DAQ_GPIO_BASE 16'h0010
`define DAQ_GPIO_SIZE 16'h00F0
`define DAQ_GPIO_BYTES 3

// Firmware readback
`define DAQ_VERSION 1
`define DAQ_VERSION_MINOR 0
`define DAQ_VERSION_MAJOR 0
// BDAQ53 board code
`define DAQ_BOARD_ID 1

// Readout streams
`define DAQ_NUM_SOURCES 4
`define DAQ_STREAM_WIDTH 32

`endif

// ==== design/daq_bus_pkg.sv ====
`include "daq_core_defines.svh"

package daq_bus_pkg;

    // One local-bus cycle as driven by the host side
    typedef struct packed {
        logic                         rd;
        logic                         wr;
        logic [`DAQ_ABUS_WIDTH-1:0]   addr;
        logic [`DAQ_DBUS_WIDTH-1:0]   wdata;
    } bus_req_t;

    // Register windows on the bus
    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_SYS,
        REGION_GPIO
    } bus_region_e;

    // Decoded access, offset relative to region base
    typedef struct packed {
        bus_region_e region;
        logic [7:0]  offset;
        logic        rd;
        logic        wr;
    } bus_sel_t;

endpackage

// ==== design/daq_stream_pkg.sv ====
`include "daq_core_defines.svh"

package daq_stream_pkg;

    // Readout word, identifier nibble on top
    typedef struct packed {
        logic [3:0]                    id;
        logic [`DAQ_STREAM_WIDTH-5:0]  payload;
    } stream_word_t;

    // Source index doubles as its position in the rotation
    typedef enum logic [1:0] {
        SRC_TDC    = 2'd0,
        SRC_TLU    = 2'd1,
        SRC_RX     = 2'd2,
        SRC_TS_INJ = 2'd3
    } source_id_e;

    // What a FIFO presents to the arbiter
    typedef struct packed {
        logic         not_empty;
        stream_word_t data;
    } fifo_src_t;

endpackage

// ==== design/bus_region_decode.sv ====
`include "daq_core_defines.svh"

module bus_region_decode
    import daq_bus_pkg::*;
(
    input  bus_req_t bus,
    output bus_sel_t sel
);

    logic hit_sys;
    logic hit_gpio;

    // Window compares, high end exclusive
    assign hit_sys  = (bus.addr >= `DAQ_SYS_BASE) &&
                      (bus.addr < (`DAQ_SYS_BASE + `DAQ_SYS_SIZE));
    assign hit_gpio = (bus.addr >= `DAQ_GPIO_BASE) &&
                      (bus.addr < (`DAQ_GPIO_BASE + `DAQ_GPIO_SIZE));

    always_comb begin
        // Default: nothing selected
        sel.region = REGION_NONE;
        sel.offset = 8'd0;
        if (hit_sys) begin
            sel.region = REGION_SYS;
            // Strip base, 256-byte window fits the offset
            sel.offset = 8'(bus.addr - `DAQ_SYS_BASE);
        end else if (hit_gpio) begin
            sel.region = REGION_GPIO;
            sel.offset = 8'(bus.addr - `DAQ_GPIO_BASE);
        end
        // Every read reaches the read mux
        // Unmapped reads latch zero there
        sel.rd = bus.rd;
        // Writes only pass for a mapped address
        sel.wr = bus.wr && (sel.region != REGION_NONE);
    end

endmodule

// ==== design/daq_system_regs.sv ====
`include "daq_core_defines.svh"

module daq_system_regs
    import daq_bus_pkg::*;
(
    input  logic                        BUS_CLK,
    input  logic                        BUS_RST,
    input  bus_sel_t                    sel,
    input  logic [`DAQ_DBUS_WIDTH-1:0]  wdata,
    output logic [`DAQ_DBUS_WIDTH-1:0]  rdata
);

    // Clock synthesizer configured, set by software
    logic si570_configured;
    logic wr_en;

    // Only act on writes into our own window
    assign wr_en = sel.wr && (sel.region == REGION_SYS);

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            si570_configured <= 1'b0;
        end else if (wr_en && (sel.offset == 8'd5)) begin
            // Flag taken from data bit 0
            si570_configured <= wdata[0];
        end
    end

    // Read value, registered later by the read mux
    always_comb begin
        case (sel.offset)
            8'd0: begin
                rdata = `DAQ_DBUS_WIDTH'(`DAQ_VERSION);
            end
            8'd1: begin
                rdata = `DAQ_DBUS_WIDTH'(`DAQ_VERSION_MINOR);
            end
            8'd2: begin
                rdata = `DAQ_DBUS_WIDTH'(`DAQ_VERSION_MAJOR);
            end
            8'd3: begin
                rdata = `DAQ_DBUS_WIDTH'(`DAQ_BOARD_ID);
            end
            8'd4: begin
                rdata = {{(`DAQ_DBUS_WIDTH-1){1'b0}}, si570_configured};
            end
            default: begin
                // Offset 5 is write-only, rest unmapped
                rdata = '0;
            end
        endcase
    end

endmodule

// ==== design/gpio_regs.sv ====
`include "daq_core_defines.svh"

module gpio_regs
    import daq_bus_pkg::*;
(
    input  logic                        BUS_CLK,
    input  logic                        BUS_RST,
    input  bus_sel_t                    sel,
    input  logic [`DAQ_DBUS_WIDTH-1:0]  wdata,
    output logic [`DAQ_DBUS_WIDTH-1:0]  rdata,
    output logic                        chip_reset_b,
    output logic                        ser_clk_sel,
    output logic [2:0]                  gpio_mode
);

    // Output bytes, byte 0 at offset 0
    logic [`DAQ_DBUS_WIDTH-1:0] gpio_q [`DAQ_GPIO_BYTES];
    // Two-stage stretch for the chip reset bit
    logic [1:0] rst_sr;
    logic       in_range;

    assign in_range = (sel.region == REGION_GPIO) && (sel.offset < `DAQ_GPIO_BYTES);

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            for (int i = 0; i < `DAQ_GPIO_BYTES; i++) begin
                gpio_q[i] <= '0;
            end
            rst_sr <= 2'b00;
        end else begin
            if (sel.wr && in_range) begin
                gpio_q[sel.offset[1:0]] <= wdata;
            end
            rst_sr <= {rst_sr[0], gpio_q[0][0]};
        end
    end

    // Readback of the selected byte, 0 outside the register
    assign rdata = in_range ? gpio_q[sel.offset[1:0]] : '0;

    // Bit 0 high holds the chip in reset
    assign chip_reset_b = ~rst_sr[1];
    // Bits 12..14 mode, bit 15 serializer clock
    assign gpio_mode   = gpio_q[1][6:4];
    assign ser_clk_sel = gpio_q[1][7];

endmodule

// ==== design/rr_stream_arbiter.sv ====
`include "daq_core_defines.svh"

module rr_stream_arbiter
    import daq_stream_pkg::*;
(
    input  logic                         BUS_CLK,
    input  logic                         BUS_RST,
    input  fifo_src_t                    src [`DAQ_NUM_SOURCES],
    input  logic [`DAQ_NUM_SOURCES-1:0]  hold,
    output logic [`DAQ_NUM_SOURCES-1:0]  src_read,
    input  logic                         arb_ready,
    output logic                         arb_write,
    output stream_word_t                 arb_data
);

    // Last source that got the grant
    source_id_e last_grant;
    logic       grant_valid;
    logic [1:0] grant_idx;
    logic [1:0] cand;
    logic       take;

    always_comb begin
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        cand        = last_grant;
        if (hold[last_grant] && src[last_grant].not_empty) begin
            // Held source keeps the grant while it has data
            grant_valid = 1'b1;
        end else begin
            // Search from the one after the last grant, wrapping
            for (int i = 1; i <= `DAQ_NUM_SOURCES; i++) begin
                cand = 2'(last_grant + i);
                if (!grant_valid && src[cand].not_empty) begin
                    grant_valid = 1'b1;
                    grant_idx   = cand;
                end
            end
        end
    end

    // No pop at all while downstream is not ready
    assign take = arb_ready && grant_valid;

    always_comb begin
        src_read = '0;
        if (take) begin
            src_read[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            // Start so that source 0 is searched first
            last_grant <= SRC_TS_INJ;
            arb_write  <= 1'b0;
        end else begin
            arb_write <= take;
            if (take) begin
                last_grant <= source_id_e'(grant_idx);
            end
        end
    end

    // Word popped this cycle goes out on the next
    always_ff @(posedge BUS_CLK) begin
        if (take) begin
            arb_data <= src[grant_idx].data;
        end
    end

endmodule

// ==== design/bus_read_mux.sv ====
`include "daq_core_defines.svh"

module bus_read_mux
    import daq_bus_pkg::*;
(
    input  logic                        BUS_CLK,
    input  logic                        BUS_RST,
    input  bus_sel_t                    sel,
    input  logic [`DAQ_DBUS_WIDTH-1:0]  sys_rdata,
    input  logic [`DAQ_DBUS_WIDTH-1:0]  gpio_rdata,
    output logic [`DAQ_DBUS_WIDTH-1:0]  rdata
);

    // Captured on the read strobe, valid one cycle later
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rdata <= '0;
        end else if (sel.rd) begin
            case (sel.region)
                REGION_SYS: begin
                    rdata <= sys_rdata;
                end
                REGION_GPIO: begin
                    rdata <= gpio_rdata;
                end
                default: begin
                    // Unmapped reads give zero
                    rdata <= '0;
                end
            endcase
        end
    end

endmodule

// ==== design/daq_core.sv ====
`include "daq_core_defines.svh"

module daq_core
    import daq_bus_pkg::*;
    import daq_stream_pkg::*;
(
    input  logic                         BUS_CLK,
    input  logic                         BUS_RST,
    input  bus_req_t                     bus,
    output logic [`DAQ_DBUS_WIDTH-1:0]   bus_rdata,
    input  fifo_src_t                    src [`DAQ_NUM_SOURCES],
    input  logic [`DAQ_NUM_SOURCES-1:0]  hold,
    output logic [`DAQ_NUM_SOURCES-1:0]  src_read,
    input  logic                         arb_ready,
    output logic                         arb_write,
    output stream_word_t                 arb_data,
    output logic                         chip_reset_b,
    output logic                         ser_clk_sel,
    output logic [2:0]                   gpio_mode
);

    bus_sel_t                   sel;
    logic [`DAQ_DBUS_WIDTH-1:0] sys_rdata;
    logic [`DAQ_DBUS_WIDTH-1:0] gpio_rdata;

    // Address to region and offset
    bus_region_decode i_bus_region_decode (
        .bus (bus),
        .sel (sel)
    );

    // Version, board id, configured flag
    daq_system_regs i_daq_system_regs (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .sel     (sel),
        .wdata   (bus.wdata),
        .rdata   (sys_rdata)
    );

    // Chip reset, serializer clock, mode
    gpio_regs i_gpio_regs (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .sel          (sel),
        .wdata        (bus.wdata),
        .rdata        (gpio_rdata),
        .chip_reset_b (chip_reset_b),
        .ser_clk_sel  (ser_clk_sel),
        .gpio_mode    (gpio_mode)
    );

    // Registered read-back
    bus_read_mux i_bus_read_mux (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .sel        (sel),
        .sys_rdata  (sys_rdata),
        .gpio_rdata (gpio_rdata),
        .rdata      (bus_rdata)
    );

    // Merge of the four readout streams
    rr_stream_arbiter i_rr_stream_arbiter (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .src       (src),
        .hold      (hold),
        .src_read  (src_read),
        .arb_ready (arb_ready),
        .arb_write (arb_write),
        .arb_data  (arb_data)
    );

endmodule

// ==== tests/daq_core_checker.sv ====
`include "daq_core_defines.svh"

module daq_core_checker
    import daq_bus_pkg::*;
    import daq_stream_pkg::*;
(
    input logic                        BUS_CLK,
    input bus_req_t                    bus,
    input logic [`DAQ_DBUS_WIDTH-1:0]  bus_rdata,
    input logic                        pin_chk,
    input logic [7:0]                  exp_val,
    input logic [`DAQ_NUM_SOURCES-1:0] src_read,
    input logic                        arb_ready,
    input logic                        arb_write,
    input stream_word_t                arb_data,
    input logic                        chip_reset_b,
    input logic                        ser_clk_sel,
    input logic [2:0]                  gpio_mode
);
    timeunit 1ns;
    timeprecision 1ps;

    // Words per source in load order, and the predicted source sequence
    stream_word_t loaded [`DAQ_NUM_SOURCES][$];
    logic [1:0]   exp_ids [$];
    int           errors = 0;
    int           errors_seen = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    // Read issued last cycle, data due now
    logic         rd_pend = 1'b0;
    logic [7:0]   rd_exp;
    logic [15:0]  rd_addr;
    logic         ready_q = 1'b0;

    always @(posedge BUS_CLK) begin
        stream_word_t want;
        if (rd_pend && (bus_rdata !== rd_exp)) begin
            errors++;
            $display("error bus_rdata @%h: got %h, expected %h", rd_addr, bus_rdata, rd_exp);
        end
        rd_pend = bus.rd;
        rd_exp  = exp_val;
        rd_addr = bus.addr;
        // Packed as {ser_clk_sel, gpio_mode, chip_reset_b}
        if (pin_chk && ({ser_clk_sel, gpio_mode, chip_reset_b} !== exp_val[4:0])) begin
            errors++;
            $display("error pins: got %h, expected %h",
                     {ser_clk_sel, gpio_mode, chip_reset_b}, exp_val[4:0]);
        end
        // At most one pop per cycle, none without downstream ready
        if ((src_read & (src_read - 1'b1)) != '0) begin
            errors++;
            $display("src_read selected more than one source in the same cycle");
        end
        if ((src_read != '0) && !arb_ready) begin
            errors++;
            $display("src_read pulsed while arb_ready was low");
        end
        // A write needs ready on the grant cycle before it
        if (arb_write && !ready_q) begin
            errors++;
            $display("arb_write was raised although arb_ready was low on the grant cycle");
        end
        ready_q = arb_ready;
        if (arb_write) begin
            if (exp_ids.size() == 0) begin
                errors++;
                $display("a word appeared on the output stream when none was expected");
            end else begin
                want = loaded[exp_ids.pop_front()].pop_front();
                if (arb_data !== want) begin
                    errors++;
                    $display("error arb_data: got %h, expected %h", arb_data, want);
                end
            end
        end
    end

    // One line per finished test
    task automatic report(input int num);
        tests_run++;
        if (errors == errors_seen) begin
            $display("test %0d: ok", num);
        end else begin
            tests_failed++;
            $display("test %0d: %0d errors", num, errors - errors_seen);
        end
        errors_seen = errors;
    endtask

endmodule

// ==== tests/daq_core_tb.sv ====
`include "daq_core_defines.svh"

module daq_core_tb
    import daq_bus_pkg::*;
    import daq_stream_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] OP_WR  = 2'd0;
    localparam logic [1:0] OP_RD  = 2'd1;
    // Pin check, and end of a test with its number in data
    localparam logic [1:0] OP_PIN = 2'd2;
    localparam logic [1:0] OP_END = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp;
    } bus_op_t;

    // Sys window 0x0300, GPIO window 0x0010, 0x0200 unmapped
    bus_op_t ops [] = '{
        '{OP_RD, 16'h0300, 8'h00, 8'h01}, '{OP_RD, 16'h0301, 8'h00, 8'h00},
        '{OP_RD, 16'h0302, 8'h00, 8'h00}, '{OP_RD, 16'h0303, 8'h00, 8'h01},
        '{OP_RD, 16'h0304, 8'h00, 8'h00}, '{OP_PIN, 16'h0000, 8'h00, 8'h01},
        '{OP_END, 16'h0000, 8'd1, 8'h00},
        '{OP_WR, 16'h0305, 8'h01, 8'h00}, '{OP_RD, 16'h0304, 8'h00, 8'h01},
        // Addresses just past each window
        // Without the upper bound they would hit the flag or GPIO byte 0
        '{OP_WR, 16'h0405, 8'hAA, 8'h00}, '{OP_WR, 16'h0110, 8'hAA, 8'h00},
        '{OP_RD, 16'h0200, 8'h00, 8'h00},
        '{OP_RD, 16'h0304, 8'h00, 8'h01}, '{OP_RD, 16'h0010, 8'h00, 8'h00},
        '{OP_END, 16'h0000, 8'd2, 8'h00},
        // Chip reset needs two clocks after the write, hence the spacing
        '{OP_WR, 16'h0010, 8'h01, 8'h00}, '{OP_RD, 16'h0010, 8'h00, 8'h01},
        '{OP_WR, 16'h0011, 8'hD0, 8'h00}, '{OP_RD, 16'h0011, 8'h00, 8'hD0},
        '{OP_PIN, 16'h0000, 8'h00, 8'h1A}, '{OP_WR, 16'h0012, 8'h5A, 8'h00},
        '{OP_RD, 16'h0012, 8'h00, 8'h5A}, '{OP_WR, 16'h0010, 8'h00, 8'h00},
        '{OP_RD, 16'h0010, 8'h00, 8'h00}, '{OP_RD, 16'h0011, 8'h00, 8'hD0},
        '{OP_RD, 16'h0012, 8'h00, 8'h5A}, '{OP_PIN, 16'h0000, 8'h00, 8'h1B},
        '{OP_END, 16'h0000, 8'd3, 8'h00}
    };

    logic                         BUS_CLK = 1'b0;
    logic                         BUS_RST;
    bus_req_t                     bus;
    logic [`DAQ_DBUS_WIDTH-1:0]   bus_rdata;
    fifo_src_t                    src [`DAQ_NUM_SOURCES];
    logic [`DAQ_NUM_SOURCES-1:0]  hold;
    logic [`DAQ_NUM_SOURCES-1:0]  src_read;
    logic                         arb_ready;
    logic                         arb_write;
    stream_word_t                 arb_data;
    logic                         chip_reset_b;
    logic                         ser_clk_sel;
    logic [2:0]                   gpio_mode;
    logic [7:0]                   exp_val;
    logic                         pin_chk;
    // Source FIFO models
    stream_word_t                 fifo [`DAQ_NUM_SOURCES][$];
    logic [31:0]                  lfsr = 32'h53d8_597b;

    always #2 BUS_CLK = ~BUS_CLK;

    daq_core i_daq_core (
        .BUS_CLK (BUS_CLK), .BUS_RST (BUS_RST), .bus (bus), .bus_rdata (bus_rdata),
        .src (src), .hold (hold), .src_read (src_read), .arb_ready (arb_ready),
        .arb_write (arb_write), .arb_data (arb_data), .chip_reset_b (chip_reset_b),
        .ser_clk_sel (ser_clk_sel), .gpio_mode (gpio_mode)
    );

    daq_core_checker i_checker (
        .BUS_CLK (BUS_CLK), .bus (bus), .bus_rdata (bus_rdata), .pin_chk (pin_chk),
        .exp_val (exp_val), .src_read (src_read), .arb_ready (arb_ready),
        .arb_write (arb_write), .arb_data (arb_data), .chip_reset_b (chip_reset_b),
        .ser_clk_sel (ser_clk_sel), .gpio_mode (gpio_mode)
    );

    // Pop on src_read, next word visible the cycle after
    always @(posedge BUS_CLK) begin
        for (int i = 0; i < `DAQ_NUM_SOURCES; i++) begin
            if (src_read[i] && (fifo[i].size() != 0)) begin
                void'(fifo[i].pop_front());
            end
            src[i] <= '{not_empty: (fifo[i].size() != 0),
                        data: (fifo[i].size() != 0) ? fifo[i][0] : '0};
        end
    end

    // Galois form, maximal-length taps
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [27:0] next_payload();
        logic [27:0] p;
        p = '0;
        for (int b = 0; b < 28; b++) begin
            lfsr = lfsr_step(lfsr);
            p = {p[26:0], lfsr[0]};
        end
        return p;
    endfunction

    // Three words per source, id nibble on top
    task automatic load_all();
        stream_word_t w;
        for (int i = 0; i < `DAQ_NUM_SOURCES; i++) begin
            for (int n = 0; n < 3; n++) begin
                w = {4'(i), next_payload()};
                fifo[i].push_back(w);
                i_checker.loaded[i].push_back(w);
            end
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((i_checker.exp_ids.size() != 0) && (n < 300)) begin
            @(posedge BUS_CLK);
            n++;
        end
        if (i_checker.exp_ids.size() != 0) begin
            $display("timeout: %0d stream words never arrived", i_checker.exp_ids.size());
            i_checker.errors++;
            i_checker.exp_ids.delete();
        end
    endtask

    // Order is the expected sequence of source ids, one digit per word
    task automatic run_stream(input int num, input logic [3:0] hold_v, input logic stall,
                              input string order);
        @(posedge BUS_CLK);
        arb_ready <= 1'b0;
        hold      <= hold_v;
        @(posedge BUS_CLK);
        load_all();
        for (int k = 0; k < order.len(); k++) begin
            i_checker.exp_ids.push_back(2'(order[k] - 8'h30));
        end
        @(posedge BUS_CLK);
        arb_ready <= 1'b1;
        if (stall) begin
            // Back-pressure mid-stream
            repeat (3) @(posedge BUS_CLK);
            arb_ready <= 1'b0;
            repeat (6) @(posedge BUS_CLK);
            arb_ready <= 1'b1;
        end
        wait_drained();
        repeat (2) @(posedge BUS_CLK);
        i_checker.report(num);
    endtask

    initial begin
        BUS_RST   = 1'b1;
        bus       = '0;
        hold      = '0;
        arb_ready = 1'b0;
        exp_val   = '0;
        pin_chk   = 1'b0;
        for (int i = 0; i < `DAQ_NUM_SOURCES; i++) begin
            src[i] = '0;
        end
        repeat (3) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;
        foreach (ops[j]) begin
            @(posedge BUS_CLK);
            bus.rd    <= (ops[j].op == OP_RD);
            bus.wr    <= (ops[j].op == OP_WR);
            bus.addr  <= ops[j].addr;
            bus.wdata <= ops[j].data;
            exp_val   <= ops[j].exp;
            pin_chk   <= (ops[j].op == OP_PIN);
            if (ops[j].op == OP_END) begin
                // Let the last read-back reach the checker
                repeat (2) @(posedge BUS_CLK);
                i_checker.report(int'(ops[j].data));
            end
        end
        // Last grant after reset is source 3, so rotation opens at 0
        run_stream(4, 4'b0000, 1'b0, "012301230123");
        run_stream(5, 4'b0010, 1'b0, "011123023023");
        run_stream(6, 4'b0000, 1'b1, "012301230123");
        $display("tests run %0d, with errors %0d, error count %0d",
                 i_checker.tests_run, i_checker.tests_failed, i_checker.errors);
        if (i_checker.errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+design
design/daq_bus_pkg.sv
design/daq_stream_pkg.sv
design/bus_region_decode.sv
design/daq_system_regs.sv
design/gpio_regs.sv
design/rr_stream_arbiter.sv
design/bus_read_mux.sv
design/daq_core.sv
tests/daq_core_checker.sv
tests/daq_core_tb.sv
